// File: hdl/ngp_game.sv
// game subsystem top level
// main CPU bus decode, sound mailbox and video timing
// both CPU buses come in as ports
`timescale 1ns/1ps

`include "ngp_settings.svh"

module ngp_game
    import ngp_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pxl_cen,

    // main CPU bus
    input  logic                      cpu_cs,
    input  logic [`NGP_ADDR_W-1:0]    cpu_addr,
    input  logic [15:0]               cpu_dout,
    input  logic [1:0]                cpu_we,
    output logic [15:0]               cpu_din,

    // sound CPU bus
    input  logic                      snd_cs,
    input  logic [`NGP_SND_BUS_W-1:0] snd_addr,
    input  logic [7:0]                snd_dout,
    input  logic                      snd_we,
    output logic [7:0]                snd_din,
    input  logic                      snd_ack,

    // video
    output logic                      hs,
    output logic                      vs,
    output logic                      lhbl,
    output logic                      lvbl,

    // interrupts and sound control
    output logic                      hirq,
    output logic                      virq,
    output logic                      snd_irq,
    output logic                      snd_nmi,
    output logic                      main_int5,
    output snd_ctrl_t                 snd_ctrl
);

    bus_req_t    req;
    logic        shd_cs;
    logic        vid_cs;
    logic        io_cs;
    logic [15:0] shd_rdata;
    logic [15:0] vid_rdata;
    logic [15:0] io_rdata;

    ngp_main_bus u_main (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .cpu_cs     ( cpu_cs    ),
        .cpu_addr   ( cpu_addr  ),
        .cpu_dout   ( cpu_dout  ),
        .cpu_we     ( cpu_we    ),
        .cpu_din    ( cpu_din   ),
        .req        ( req       ),
        .shd_cs     ( shd_cs    ),
        .vid_cs     ( vid_cs    ),
        .io_cs      ( io_cs     ),
        .shd_rdata  ( shd_rdata ),
        .vid_rdata  ( vid_rdata ),
        .io_rdata   ( io_rdata  )
    );

    // shared RAM and latches
    ngp_snd_mailbox u_snd (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .req        ( req       ),
        .shd_cs     ( shd_cs    ),
        .io_cs      ( io_cs     ),
        .shd_rdata  ( shd_rdata ),
        .io_rdata   ( io_rdata  ),
        .snd_cs     ( snd_cs    ),
        .snd_addr   ( snd_addr  ),
        .snd_dout   ( snd_dout  ),
        .snd_we     ( snd_we    ),
        .snd_din    ( snd_din   ),
        .snd_ack    ( snd_ack   ),
        .snd_irq    ( snd_irq   ),
        .snd_nmi    ( snd_nmi   ),
        .main_int5  ( main_int5 ),
        .snd_ctrl   ( snd_ctrl  )
    );

    // raster timing
    ngp_video_timing u_video (
        .clk        ( clk       ),
        .rst_n      ( rst_n     ),
        .pxl_cen    ( pxl_cen   ),
        .req        ( req       ),
        .vid_cs     ( vid_cs    ),
        .vid_rdata  ( vid_rdata ),
        .hs         ( hs        ),
        .vs         ( vs        ),
        .lhbl       ( lhbl      ),
        .lvbl       ( lvbl      ),
        .hirq       ( hirq      ),
        .virq       ( virq      )
    );

endmodule

// File: hdl/ngp_main_bus.sv
// main CPU bus
// decodes accesses into shared RAM, video and sound I/O regions,
// forwards the request to the targets and muxes the returned read word
`timescale 1ns/1ps

`include "ngp_settings.svh"

module ngp_main_bus
    import ngp_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,

    // main CPU side
    input  logic                   cpu_cs,
    input  logic [`NGP_ADDR_W-1:0] cpu_addr,
    input  logic [15:0]            cpu_dout,
    input  logic [1:0]             cpu_we,
    output logic [15:0]            cpu_din,

    // target side
    output bus_req_t               req,
    output logic                   shd_cs,
    output logic                   vid_cs,
    output logic                   io_cs,
    input  logic [15:0]            shd_rdata,
    input  logic [15:0]            vid_rdata,
    input  logic [15:0]            io_rdata
);

    bus_region_e            region;
    bus_region_e            rd_sel;
    logic [`NGP_SEL_W-1:0]  sel_bits;
    logic                   cpu_rd;

    // region comes from the top word address bits
    assign sel_bits = cpu_addr[`NGP_ADDR_W-1 -: `NGP_SEL_W];

    always_comb begin
        case (sel_bits)
            `NGP_SHD_BASE: region = REG_SHD;
            `NGP_VID_BASE: region = REG_VID;
            `NGP_IO_BASE:  region = REG_IO;
            default:       region = REG_NONE;
        endcase
    end

    // same request word to all targets
    // only the selected one sees its cs
    assign req = '{addr: cpu_addr, data: cpu_dout, we: cpu_we};

    assign shd_cs = cpu_cs && (region == REG_SHD);
    assign vid_cs = cpu_cs && (region == REG_VID);
    assign io_cs  = cpu_cs && (region == REG_IO);

    // a read is a cs cycle with no byte enable
    assign cpu_rd = cpu_cs && (cpu_we == 2'b00);

    // remember which target answers the pending read
    // writes leave the last read selection alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel <= REG_NONE;
        end else if (cpu_rd) begin
            rd_sel <= region;
        end
    end

    // targets hold their registered read word
    // so cpu_din stays put until the next read
    always_comb begin
        case (rd_sel)
            REG_SHD: cpu_din = shd_rdata;
            REG_VID: cpu_din = vid_rdata;
            REG_IO:  cpu_din = io_rdata;
            // unmapped reads float high
            default: cpu_din = 16'hffff;
        endcase
    end

endmodule

// File: hdl/ngp_pkg.sv
// handheld console subsystem types
// bus request word, main bus region decode and sound control bits

`include "ngp_settings.svh"

package ngp_pkg;

    // one main CPU access as seen by every target
    typedef struct packed {
        // word address
        logic [`NGP_ADDR_W-1:0] addr;
        // write data
        logic [15:0]            data;
        // byte write enables, all zero for a read
        logic [1:0]             we;
    } bus_req_t;

    // main bus regions
    typedef enum logic [1:0] {
        REG_NONE,
        REG_SHD,
        REG_VID,
        REG_IO
    } bus_region_e;

    // sound CPU control register
    // en is bit 1, rstn is bit 0
    typedef struct packed {
        logic en;
        logic rstn;
    } snd_ctrl_t;

endpackage

// File: hdl/ngp_settings.svh
// handheld console subsystem settings
// address widths, bus region bases and raster totals
// raster values are kept small so frames stay short in simulation
`ifndef NGP_SETTINGS_SVH
`define NGP_SETTINGS_SVH

// main bus word address, bits 14..1 of the byte address
`define NGP_ADDR_W      14
// upper word address bits used for region decode
`define NGP_SEL_W       4
`define NGP_SHD_BASE    4'h1
`define NGP_VID_BASE    4'h2
`define NGP_IO_BASE     4'h3

// shared sound RAM, 1024 words = 2 KB
`define NGP_SND_ADDR_W  10
// sound side byte address, RAM below 2 KB, latch at all ones
`define NGP_SND_BUS_W   (`NGP_SND_ADDR_W + 2)

// pixels per line
`define NGP_H_TOTAL     40
`define NGP_H_VISIBLE   32
`define NGP_HS_START    34
`define NGP_HS_END      37
// lines per frame
`define NGP_V_TOTAL     24
`define NGP_V_VISIBLE   18
`define NGP_VS_START    20
`define NGP_VS_END      21

`endif

// File: hdl/ngp_snd_mailbox.sv
// sound mailbox
// 2 KB shared RAM between the main and sound CPUs, the two
// communication latches, irq/nmi/int5 flags and sound control
`timescale 1ns/1ps

`include "ngp_settings.svh"

module ngp_snd_mailbox
    import ngp_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    // main CPU side
    input  bus_req_t                  req,
    input  logic                      shd_cs,
    input  logic                      io_cs,
    output logic [15:0]               shd_rdata,
    output logic [15:0]               io_rdata,

    // sound CPU side, byte wide
    input  logic                      snd_cs,
    input  logic [`NGP_SND_BUS_W-1:0] snd_addr,
    input  logic [7:0]                snd_dout,
    input  logic                      snd_we,
    output logic [7:0]                snd_din,
    input  logic                      snd_ack,

    // interrupts and control
    output logic                      snd_irq,
    output logic                      snd_nmi,
    output logic                      main_int5,
    output snd_ctrl_t                 snd_ctrl
);

    logic [15:0]                ram [0:(1 << `NGP_SND_ADDR_W)-1];
    logic [`NGP_SND_ADDR_W-1:0] shd_addr;
    logic [`NGP_SND_ADDR_W-1:0] snd_word;
    logic                       snd_lane;
    logic                       snd_ram_sel;
    logic                       snd_latch_sel;
    logic                       snd_ram_we;
    logic                       snd_latch_we;
    logic [2:0]                 io_off;
    logic                       io_wr;
    logic                       io_rd;
    // written by main, read by sound
    logic [7:0]                 main_latch;
    // written by sound, read by main
    logic [7:0]                 snd_latch;

    assign shd_addr = req.addr[`NGP_SND_ADDR_W-1:0];

    // sound byte address split into word and lane
    assign snd_word      = snd_addr[`NGP_SND_ADDR_W:1];
    assign snd_lane      = snd_addr[0];
    assign snd_ram_sel   = !snd_addr[`NGP_SND_BUS_W-1];
    assign snd_latch_sel = &snd_addr;
    assign snd_ram_we    = snd_cs && snd_we && snd_ram_sel;
    assign snd_latch_we  = snd_cs && snd_we && snd_latch_sel;

    // I/O registers live in the low byte
    assign io_off = req.addr[2:0];
    assign io_wr  = io_cs && req.we[0];
    assign io_rd  = io_cs && (req.we == 2'b00);

    // dual ported RAM, main writes per byte lane, sound writes one byte
    always_ff @(posedge clk) begin
        if (shd_cs) begin
            for (int b = 0; b < 2; b++) begin
                if (req.we[b]) begin
                    ram[shd_addr][b*8 +: 8] <= req.data[b*8 +: 8];
                end
            end
        end
        if (snd_ram_we) begin
            ram[snd_word][{snd_lane, 3'b000} +: 8] <= snd_dout;
        end
        // read ports, old data on a collision
        if (shd_cs && (req.we == 2'b00)) begin
            shd_rdata <= ram[shd_addr];
        end
        if (snd_cs && !snd_we) begin
            if (snd_latch_sel) begin
                snd_din <= main_latch;
            end else if (snd_ram_sel) begin
                snd_din <= ram[snd_word][{snd_lane, 3'b000} +: 8];
            end else begin
                snd_din <= 8'hff;
            end
        end
    end

    // main side register readback
    always_ff @(posedge clk) begin
        if (io_rd) begin
            case (io_off)
                3'd0:    io_rdata <= {8'h00, main_latch};
                3'd1:    io_rdata <= {8'h00, snd_latch};
                3'd2:    io_rdata <= {14'd0, snd_ctrl};
                default: io_rdata <= 16'h0000;
            endcase
        end
    end

    // latches, flags and control
    // a set in the same cycle as its clear wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_latch <= 8'h00;
            snd_latch  <= 8'h00;
            snd_irq    <= 1'b0;
            snd_nmi    <= 1'b0;
            main_int5  <= 1'b0;
            snd_ctrl   <= '0;
        end else begin
            if (io_wr && io_off == 3'd0) begin
                main_latch <= req.data[7:0];
            end
            if (snd_latch_we) begin
                snd_latch <= snd_dout;
            end
            if (io_wr && io_off == 3'd2) begin
                snd_ctrl <= req.data[1:0];
            end
            // main latch write raises irq, ack drops it
            if (io_wr && io_off == 3'd0) begin
                snd_irq <= 1'b1;
            end else if (snd_ack) begin
                snd_irq <= 1'b0;
            end
            // single cycle nmi per trigger write
            snd_nmi <= io_wr && (io_off == 3'd3);
            // sound latch write raises int5, I/O 4 acks it
            if (snd_latch_we) begin
                main_int5 <= 1'b1;
            end else if (io_wr && io_off == 3'd4) begin
                main_int5 <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/ngp_video_timing.sv
// video timing
// pixel and line counters, sync and blanking, plus the
// programmable line interrupt and the vertical blank interrupt
`timescale 1ns/1ps

`include "ngp_settings.svh"

module ngp_video_timing
    import ngp_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,

    // register access from the main bus
    input  bus_req_t    req,
    input  logic        vid_cs,
    output logic [15:0] vid_rdata,

    // raster outputs
    output logic        hs,
    output logic        vs,
    output logic        lhbl,
    output logic        lvbl,
    output logic        hirq,
    output logic        virq
);

    localparam int HW = $clog2(`NGP_H_TOTAL);
    localparam int VW = $clog2(`NGP_V_TOTAL);

    logic [HW-1:0] hcnt;
    logic [VW-1:0] vcnt;
    logic          line_end;
    logic          line_new;
    logic [VW-1:0] hirq_line;
    // bit0 hirq, bit1 virq
    logic [1:0]    irq_en;
    logic [1:0]    reg_off;
    logic          vid_wr;
    logic          vid_rd;
    logic          hirq_evt;
    logic          virq_evt;

    assign reg_off = req.addr[1:0];
    assign vid_wr  = vid_cs && req.we[0];
    assign vid_rd  = vid_cs && (req.we == 2'b00);

    // last pixel of a line, on a pixel enable
    assign line_end = pxl_cen && (hcnt == HW'(`NGP_H_TOTAL - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (line_end) begin
            hcnt <= '0;
            vcnt <= (vcnt == VW'(`NGP_V_TOTAL - 1)) ? '0 : vcnt + 1'b1;
        end else if (pxl_cen) begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // sync and blanking, one clock behind the counters
    // line_new marks the first clock of pixel 0 on a new line
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hs       <= 1'b0;
            vs       <= 1'b0;
            lhbl     <= 1'b1;
            lvbl     <= 1'b1;
            line_new <= 1'b0;
        end else begin
            hs       <= hcnt >= HW'(`NGP_HS_START) && hcnt < HW'(`NGP_HS_END);
            vs       <= vcnt >= VW'(`NGP_VS_START) && vcnt < VW'(`NGP_VS_END);
            lhbl     <= hcnt < HW'(`NGP_H_VISIBLE);
            lvbl     <= vcnt < VW'(`NGP_V_VISIBLE);
            line_new <= line_end;
        end
    end

    // line events, gated by their enables
    assign hirq_evt = line_new && irq_en[0] && (vcnt == hirq_line);
    assign virq_evt = line_new && irq_en[1] && (vcnt == VW'(`NGP_V_VISIBLE));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hirq_line <= '0;
            irq_en    <= 2'b00;
            hirq      <= 1'b0;
            virq      <= 1'b0;
        end else begin
            if (vid_wr && reg_off == 2'd0) begin
                hirq_line <= req.data[VW-1:0];
            end
            if (vid_wr && reg_off == 2'd1) begin
                irq_en <= req.data[1:0];
            end
            // write 1 to clear, a new event wins
            if (hirq_evt) begin
                hirq <= 1'b1;
            end else if (vid_wr && reg_off == 2'd2 && req.data[0]) begin
                hirq <= 1'b0;
            end
            if (virq_evt) begin
                virq <= 1'b1;
            end else if (vid_wr && reg_off == 2'd2 && req.data[1]) begin
                virq <= 1'b0;
            end
        end
    end

    // register readback, flags visible at the clear offset
    always_ff @(posedge clk) begin
        if (vid_rd) begin
            case (reg_off)
                2'd0:    vid_rdata <= {{(16-VW){1'b0}}, hirq_line};
                2'd1:    vid_rdata <= {14'd0, irq_en};
                2'd2:    vid_rdata <= {14'd0, virq, hirq};
                default: vid_rdata <= {{(16-VW){1'b0}}, vcnt};
            endcase
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the game subsystem testbench with Verilator, run it and
# decide pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_ngp_game

if ! verilator --binary --timing --assert -f src.f \
        --top-module ngp_game_tb -o "$BIN"; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
fi

echo "pass message not found in $LOG"
exit 1

// File: src.f
+incdir+hdl
hdl/ngp_pkg.sv
hdl/ngp_main_bus.sv
hdl/ngp_snd_mailbox.sv
hdl/ngp_video_timing.sv
hdl/ngp_game.sv
tests/ngp_game_asserts.sv
tests/ngp_game_tb.sv

// File: tests/ngp_game_asserts.sv
// interrupt and raster checks, bound into the mailbox and video timing
// nmi pulse width, flags held low in reset, lhbl against the pixel count
`timescale 1ns/1ps

`include "ngp_settings.svh"

module ngp_game_asserts #(
    parameter int CNT_W      = $clog2(`NGP_H_TOTAL),
    // only the mailbox has an nmi
    parameter bit NMI_CHK    = 1'b1,
    // only the video block has a pixel counter
    parameter bit RASTER_CHK = 1'b1
) (
    input logic             clk,
    input logic             rst_n,
    input logic             nmi,
    input logic [2:0]       irqs,
    input logic [CNT_W-1:0] hcnt,
    input logic             lhbl
);

    if (NMI_CHK) begin : g_nmi
        // nmi is one clock per trigger
        nmi_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
            nmi |=> !nmi)
            else $error("snd_nmi stayed high for two consecutive cycles");
    end

    // async reset keeps every flag low
    irq_low_in_reset: assert property (@(posedge clk) !rst_n |-> (irqs == 3'b000))
        else $error("interrupt flag high while reset is asserted");

    if (RASTER_CHK) begin : g_raster
        // blanking lags the pixel counter by one clock
        lhbl_follows_hcnt: assert property (@(posedge clk) disable iff (!rst_n)
            lhbl == ($past(hcnt) < CNT_W'(`NGP_H_VISIBLE)))
            else $error("lhbl does not follow the pixel count");
    end

endmodule

// mailbox has no raster counters
bind ngp_snd_mailbox ngp_game_asserts #(.RASTER_CHK(1'b0)) u_snd_asserts (
    .clk   ( clk                             ),
    .rst_n ( rst_n                           ),
    .nmi   ( snd_nmi                         ),
    .irqs  ( {snd_irq, snd_nmi, main_int5}   ),
    .hcnt  ( '0                              ),
    .lhbl  ( 1'b1                            )
);

// video timing has no nmi
bind ngp_video_timing ngp_game_asserts #(.NMI_CHK(1'b0)) u_vid_asserts (
    .clk   ( clk                ),
    .rst_n ( rst_n              ),
    .nmi   ( 1'b0               ),
    .irqs  ( {hirq, virq, 1'b0} ),
    .hcnt  ( hcnt               ),
    .lhbl  ( lhbl               )
);

// File: tests/ngp_game_tb.sv
// testbench for the game subsystem
// drives the main and sound CPU buses and checks shared RAM, latches,
// sound control and the raster interrupts
`timescale 1ns/1ps

`include "ngp_settings.svh"

module ngp_game_tb
    import ngp_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    // pxl_cen is high every other clock
    localparam int FRAME_CYCLES = 2 * `NGP_H_TOTAL * `NGP_V_TOTAL;
    // three frames of raster plus the bus tests
    localparam int TEST_CYCLES  = 3 * FRAME_CYCLES + 500;
    localparam int OFF_W        = `NGP_ADDR_W - `NGP_SEL_W;
    localparam int SND_W        = `NGP_SND_ADDR_W;
    localparam logic [`NGP_SND_BUS_W-1:0] SND_LATCH = '1;
    // interrupt selectors for expect_level
    localparam int SEL_SND_IRQ  = 0;
    localparam int SEL_INT5     = 1;
    localparam int SEL_HIRQ     = 2;
    localparam int SEL_VIRQ     = 3;

    logic                      clk = 1'b0;
    logic                      rst_n = 1'b1;
    logic                      pxl_cen = 1'b0;
    logic                      cpu_cs;
    logic [`NGP_ADDR_W-1:0]    cpu_addr;
    logic [15:0]               cpu_dout;
    logic [1:0]                cpu_we;
    logic [15:0]               cpu_din;
    logic                      snd_cs;
    logic [`NGP_SND_BUS_W-1:0] snd_addr;
    logic [7:0]                snd_dout;
    logic                      snd_we;
    logic [7:0]                snd_din;
    logic                      snd_ack;
    logic                      hs;
    logic                      vs;
    logic                      lhbl;
    logic                      lvbl;
    logic                      hirq;
    logic                      virq;
    logic                      snd_irq;
    logic                      snd_nmi;
    logic                      main_int5;
    snd_ctrl_t                 snd_ctrl;
    logic [31:0]               rng = 32'he66f_3e1d;
    int                        nmi_cnt = 0;

    ngp_game dut_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
    end

    // nmi pulses seen so far
    always @(negedge clk) begin
        if (snd_nmi) begin
            nmi_cnt <= nmi_cnt + 1;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // region select in the top bits, word offset below
    function automatic logic [`NGP_ADDR_W-1:0] region_addr(input logic [`NGP_SEL_W-1:0] base,
                                                           input int off);
        return {base, OFF_W'(off)};
    endfunction

    // sound byte address of one lane of a RAM word
    function automatic logic [`NGP_SND_BUS_W-1:0] snd_byte_addr(input int word, input logic lane);
        return {1'b0, SND_W'(word), lane};
    endfunction

    function automatic logic irq_level(input int which);
        case (which)
            SEL_SND_IRQ: return snd_irq;
            SEL_INT5:    return main_int5;
            SEL_HIRQ:    return hirq;
            default:     return virq;
        endcase
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp)
            else stop_with_failure($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_value(name, {15'd0, got}, {15'd0, exp});
    endtask

    task automatic main_write(input logic [`NGP_ADDR_W-1:0] addr, input logic [15:0] data,
                              input logic [1:0] we);
        @(posedge clk);
        cpu_cs   <= 1'b1;
        cpu_addr <= addr;
        cpu_dout <= data;
        cpu_we   <= we;
        @(posedge clk);
        cpu_cs   <= 1'b0;
        cpu_we   <= 2'b00;
    endtask

    // read word is valid one clock after the cs cycle
    task automatic main_read(input logic [`NGP_ADDR_W-1:0] addr, input logic [15:0] exp,
                             input string name);
        @(posedge clk);
        cpu_cs   <= 1'b1;
        cpu_addr <= addr;
        cpu_we   <= 2'b00;
        @(posedge clk);
        cpu_cs   <= 1'b0;
        @(negedge clk);
        check_value(name, cpu_din, exp);
    endtask

    task automatic snd_write(input logic [`NGP_SND_BUS_W-1:0] addr, input logic [7:0] data);
        @(posedge clk);
        snd_cs   <= 1'b1;
        snd_addr <= addr;
        snd_dout <= data;
        snd_we   <= 1'b1;
        @(posedge clk);
        snd_cs   <= 1'b0;
        snd_we   <= 1'b0;
    endtask

    task automatic snd_read(input logic [`NGP_SND_BUS_W-1:0] addr, input logic [7:0] exp,
                            input string name);
        @(posedge clk);
        snd_cs   <= 1'b1;
        snd_addr <= addr;
        snd_we   <= 1'b0;
        @(posedge clk);
        snd_cs   <= 1'b0;
        @(negedge clk);
        check_value(name, {8'h00, snd_din}, {8'h00, exp});
    endtask

    task automatic pulse_ack();
        @(posedge clk);
        snd_ack <= 1'b1;
        @(posedge clk);
        snd_ack <= 1'b0;
    endtask

    // bounded wait for a flag to go high
    task automatic expect_level(input int which, input string name, input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!irq_level(which) && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        assert (irq_level(which))
            else stop_with_failure($sformatf("%s did not rise within %0d cycles", name, limit));
    endtask

    // interrupts stay quiet while sync and blanking keep running
    task automatic check_quiet(input int cycles);
        logic seen_hs;
        logic seen_vs;
        logic seen_hblank;
        seen_hs     = 1'b0;
        seen_vs     = 1'b0;
        seen_hblank = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            assert (!hirq && !virq)
                else stop_with_failure("raster interrupt rose while both enables were off");
            seen_hs     = seen_hs | hs;
            seen_vs     = seen_vs | vs;
            seen_hblank = seen_hblank | !lhbl;
        end
        assert (seen_hs && seen_vs && seen_hblank)
            else stop_with_failure("hs, vs or horizontal blanking never went active in a frame");
    endtask

    task automatic test_reset_values();
        @(negedge clk);
        check_bit("snd_irq", snd_irq, 1'b0);
        check_bit("snd_nmi", snd_nmi, 1'b0);
        check_bit("main_int5", main_int5, 1'b0);
        check_bit("hirq", hirq, 1'b0);
        check_bit("virq", virq, 1'b0);
        check_bit("hs", hs, 1'b0);
        check_bit("vs", vs, 1'b0);
        check_value("snd_ctrl", {14'd0, snd_ctrl}, 16'h0000);
        main_read(region_addr(`NGP_IO_BASE, 1), 16'h0000, "cpu_din sound latch");
        main_read(region_addr(`NGP_IO_BASE, 0), 16'h0000, "cpu_din main latch");
        snd_read(SND_LATCH, 8'h00, "snd_din main latch");
    endtask

    task automatic test_shared_ram();
        logic [15:0] words [0:7];
        int          offs [0:7];
        logic [7:0]  byte_val;
        // one word in each 128 word block, so no two collide
        for (int i = 0; i < 8; i++) begin
            rng = xorshift32(rng);
            words[i] = rng[15:0];
            offs[i] = i * 128 + int'(rng[22:16]);
            main_write(region_addr(`NGP_SHD_BASE, offs[i]), words[i], 2'b11);
        end
        for (int i = 0; i < 8; i++) begin
            main_read(region_addr(`NGP_SHD_BASE, offs[i]), words[i], "cpu_din shared ram");
            snd_read(snd_byte_addr(offs[i], 1'b0), words[i][7:0], "snd_din low byte");
            snd_read(snd_byte_addr(offs[i], 1'b1), words[i][15:8], "snd_din high byte");
        end
        // odd sound byte lands in the high lane
        rng = xorshift32(rng);
        byte_val = rng[7:0];
        snd_write(snd_byte_addr(offs[0], 1'b1), byte_val);
        main_read(region_addr(`NGP_SHD_BASE, offs[0]), {byte_val, words[0][7:0]},
                  "cpu_din after sound byte write");
        // low lane only
        main_write(region_addr(`NGP_SHD_BASE, offs[1]), 16'h5aa5, 2'b01);
        main_read(region_addr(`NGP_SHD_BASE, offs[1]), {words[1][15:8], 8'ha5},
                  "cpu_din after byte enable write");
        main_read(region_addr(4'h0, 5), 16'hffff, "cpu_din unmapped");
        main_read(region_addr(4'h9, 77), 16'hffff, "cpu_din unmapped");
    endtask

    task automatic test_main_to_snd();
        logic [7:0] val;
        int         nmi_before;
        rng = xorshift32(rng);
        val = rng[7:0];
        main_write(region_addr(`NGP_IO_BASE, 0), {8'h00, val}, 2'b11);
        expect_level(SEL_SND_IRQ, "snd_irq", 4);
        snd_read(SND_LATCH, val, "snd_din main latch");
        pulse_ack();
        @(negedge clk);
        check_bit("snd_irq", snd_irq, 1'b0);
        nmi_before = nmi_cnt;
        main_write(region_addr(`NGP_IO_BASE, 3), 16'h0001, 2'b11);
        repeat (6) @(negedge clk);
        check_value("snd_nmi pulse count", 16'(nmi_cnt - nmi_before), 16'h0001);
    endtask

    task automatic test_snd_to_main();
        logic [7:0] val;
        rng = xorshift32(rng);
        val = rng[7:0];
        snd_write(SND_LATCH, val);
        expect_level(SEL_INT5, "main_int5", 4);
        main_read(region_addr(`NGP_IO_BASE, 1), {8'h00, val}, "cpu_din sound latch");
        main_write(region_addr(`NGP_IO_BASE, 4), 16'h0001, 2'b11);
        @(negedge clk);
        check_bit("main_int5", main_int5, 1'b0);
    endtask

    // rstn is bit 0, en is bit 1
    task automatic test_snd_ctrl(input logic [1:0] val);
        main_write(region_addr(`NGP_IO_BASE, 2), {14'd0, val}, 2'b11);
        @(negedge clk);
        check_bit("snd_ctrl.rstn", snd_ctrl.rstn, val[0]);
        check_bit("snd_ctrl.en", snd_ctrl.en, val[1]);
        main_read(region_addr(`NGP_IO_BASE, 2), {14'd0, val}, "cpu_din sound control");
    endtask

    task automatic test_raster();
        main_write(region_addr(`NGP_VID_BASE, 0), 16'd5, 2'b11);
        main_write(region_addr(`NGP_VID_BASE, 1), 16'h0003, 2'b11);
        expect_level(SEL_HIRQ, "hirq", FRAME_CYCLES + 100);
        main_read(region_addr(`NGP_VID_BASE, 3), 16'd5, "cpu_din line at hirq");
        check_bit("lvbl", lvbl, 1'b1);
        expect_level(SEL_VIRQ, "virq", FRAME_CYCLES + 100);
        main_read(region_addr(`NGP_VID_BASE, 3), 16'(`NGP_V_VISIBLE), "cpu_din line at virq");
        check_bit("lvbl", lvbl, 1'b0);
        check_bit("hirq", hirq, 1'b1);
        // write 1 to clear both
        main_write(region_addr(`NGP_VID_BASE, 2), 16'h0003, 2'b11);
        @(negedge clk);
        check_bit("hirq", hirq, 1'b0);
        check_bit("virq", virq, 1'b0);
        main_write(region_addr(`NGP_VID_BASE, 1), 16'h0000, 2'b11);
        check_quiet(FRAME_CYCLES + 100);
    endtask

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        stop_with_failure("watchdog timeout, the tests did not finish in time");
    end

    initial begin
        cpu_cs   <= 1'b0;
        cpu_addr <= '0;
        cpu_dout <= 16'h0000;
        cpu_we   <= 2'b00;
        snd_cs   <= 1'b0;
        snd_addr <= '0;
        snd_dout <= 8'h00;
        snd_we   <= 1'b0;
        snd_ack  <= 1'b0;
        // falling edge at time zero fires the async reset
        rst_n    <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n    <= 1'b1;
        test_reset_values();
        test_shared_ram();
        test_main_to_snd();
        test_snd_to_main();
        test_snd_ctrl(2'b11);
        test_snd_ctrl(2'b01);
        test_raster();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
